// ==== src/sort_defs.svh ====
`ifndef SORT_DEFS_SVH
`define SORT_DEFS_SVH

// Width of the sort key carried in every record
`define SORT_KEY_W 32

// Number of input lanes feeding the merge tree
// The tree is a full binary tree, so this must be a power of two
`define SORT_WAY 8

// Entries in each FIFO between tree levels
// Two entries let a cell write while its parent reads
`define SORT_FIFO_DEPTH 2

// Record width is the key plus the last flag
`define SORT_REC_W (`SORT_KEY_W + 1)

// Tree size derived from the lane count
`define SORT_NODES (2 * `SORT_WAY - 1)

`define SORT_CELLS (`SORT_WAY - 1)

`endif

// ==== src/sort_rec_pkg.sv ====
`include "sort_defs.svh"

package sort_rec_pkg;

  // Keys compare as unsigned numbers
  typedef logic [`SORT_KEY_W-1:0] sort_key_t;

  // One record of a sorted run
  // A record with last set ends the run and its key carries no data
  typedef struct packed {
    sort_key_t key;
    logic      last;
  } sort_rec_t;

  // Flattened width of a record, kept in step with the struct above
  localparam int unsigned sort_rec_w = `SORT_REC_W;

  // Terminator record used when a cell merges two run ends
  function automatic sort_rec_t make_term();
    sort_rec_t rec;
    rec.key  = '0;
    rec.last = 1'b1;
    return rec;
  endfunction

endpackage

// ==== src/merge_tree_pkg.sv ====
`include "sort_defs.svh"

package merge_tree_pkg;

  // Lane number at the tree inputs
  typedef logic [$clog2(`SORT_WAY)-1:0] lane_idx_t;

  // Heap-style node number, root is 1 and node n has children 2n and 2n+1
  // Node 0 is never used
  typedef logic [$clog2(2 * `SORT_WAY)-1:0] node_idx_t;

  localparam node_idx_t root_node = node_idx_t'(1);

  // Lane i feeds leaf node first_leaf + i
  localparam node_idx_t first_leaf = node_idx_t'(`SORT_WAY);

  localparam int unsigned node_cnt = `SORT_NODES;
  localparam int unsigned cell_cnt = `SORT_CELLS;

endpackage

// ==== src/two_entry_fifo.sv ====
`include "sort_defs.svh"

module two_entry_fifo
  import sort_rec_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       enq,
  input  logic       deq,
  input  sort_rec_t  din,
  output sort_rec_t  dot,
  output logic       emp,
  output logic       full,
  output logic [1:0] cnt
);

  localparam int unsigned depth = `SORT_FIFO_DEPTH;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;

  sort_rec_t        mem [depth];
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] wr_ptr;
  logic             wr_en;
  logic             rd_en;

  assign rd_en = deq & ~emp;

  // A full buffer still takes a write when the head leaves in the same cycle
  assign wr_en = enq & (~full | deq);

  assign emp  = (cnt == 2'd0);
  assign full = (cnt == 2'(depth));
  assign dot  = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      cnt    <= 2'd0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   cnt <= cnt + 2'd1;
        2'b01:   cnt <= cnt - 2'd1;
        default: cnt <= cnt;
      endcase
    end
  end

endmodule

// ==== src/lane_inbuf.sv ====
module lane_inbuf
  import sort_rec_pkg::*;
(
  input  logic      CLK,
  input  logic      rst_n,
  input  logic      enq,
  input  sort_rec_t din,
  output logic      full,
  input  logic      leaf_full,
  output logic      leaf_enq,
  output sort_rec_t leaf_din,
  input  logic      round_done
);

  sort_rec_t stage_rec;
  logic      stage_vld;
  logic      run_lock;
  logic      accept;

  // The stage drains into the leaf FIFO whenever that FIFO has room
  assign leaf_enq = stage_vld & ~leaf_full;
  assign leaf_din = stage_rec;

  // A stage that can drain this cycle frees its slot for a new record
  assign full   = run_lock | (stage_vld & leaf_full);
  assign accept = enq & ~full;

  always_ff @(posedge CLK) begin
    if (accept) begin
      stage_rec <= din;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      stage_vld <= 1'b0;
    end else if (accept) begin
      stage_vld <= 1'b1;
    end else if (leaf_enq) begin
      stage_vld <= 1'b0;
    end
  end

  // Once this lane's terminator is in, the next run waits for the round to
  // leave the root, otherwise its keys would merge with the current round
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      run_lock <= 1'b0;
    end else if (accept && din.last) begin
      run_lock <= 1'b1;
    end else if (round_done) begin
      run_lock <= 1'b0;
    end
  end

endmodule

// ==== src/merge_cell.sv ====
module merge_cell
  import sort_rec_pkg::*;
(
  input  logic      a_rdy,
  input  logic      b_rdy,
  input  sort_rec_t a_rec,
  input  sort_rec_t b_rec,
  output logic      a_deq,
  output logic      b_deq,
  input  logic      out_full,
  output logic      out_enq,
  output sort_rec_t out_rec
);

  logic fire;
  logic pick_a;
  logic both_last;

  // A decision needs both heads, since an absent head might hold the smaller key
  assign fire = a_rdy & b_rdy & ~out_full;

  always_comb begin
    both_last = 1'b0;
    pick_a    = 1'b1;
    case ({a_rec.last, b_rec.last})
      2'b00: begin
        // Ties go to the a side
        pick_a = (a_rec.key <= b_rec.key);
      end
      2'b10: begin
        // Side a has ended its run, keep draining b
        pick_a = 1'b0;
      end
      2'b01: begin
        pick_a = 1'b1;
      end
      default: begin
        // Both runs ended, so the two terminators become one
        both_last = 1'b1;
        pick_a    = 1'b1;
      end
    endcase
  end

  assign a_deq   = fire & (both_last | pick_a);
  assign b_deq   = fire & (both_last | ~pick_a);
  assign out_enq = fire;

  always_comb begin
    if (both_last) begin
      out_rec = make_term();
    end else if (pick_a) begin
      out_rec = a_rec;
    end else begin
      out_rec = b_rec;
    end
  end

endmodule

// ==== src/merge_sort_tree.sv ====
`include "sort_defs.svh"

module merge_sort_tree
  import sort_rec_pkg::*, merge_tree_pkg::*;
(
  input  logic                           CLK,
  input  logic                           rst_n,
  input  sort_rec_t [`SORT_WAY-1:0]      lane_din,
  input  logic      [`SORT_WAY-1:0]      enq,
  output logic      [`SORT_WAY-1:0]      full,
  input  logic                           deq,
  output sort_rec_t                      dot,
  output logic                           emp
);

  // FIFO signals indexed by tree node, entry 1 is the root
  logic      f_enq  [1:node_cnt];
  logic      f_deq  [1:node_cnt];
  logic      f_emp  [1:node_cnt];
  logic      f_full [1:node_cnt];
  sort_rec_t f_din  [1:node_cnt];
  sort_rec_t f_dot  [1:node_cnt];

  logic round_done;

  // The round is over when its single terminator leaves the root
  assign round_done = deq & ~f_emp[root_node] & f_dot[root_node].last;

  assign f_deq[root_node] = deq;
  assign dot              = f_dot[root_node];
  assign emp              = f_emp[root_node];

  for (genvar n = 1; n <= node_cnt; n++) begin : g_fifo
    localparam node_idx_t node = node_idx_t'(n);

    two_entry_fifo fifo_i (
      .CLK   (CLK),
      .rst_n (rst_n),
      .enq   (f_enq[node]),
      .deq   (f_deq[node]),
      .din   (f_din[node]),
      .dot   (f_dot[node]),
      .emp   (f_emp[node]),
      .full  (f_full[node]),
      .cnt   ()
    );
  end

  for (genvar n = 0; n < `SORT_WAY; n++) begin : g_lane
    localparam lane_idx_t lane = lane_idx_t'(n);
    localparam node_idx_t leaf = first_leaf + node_idx_t'(lane);

    lane_inbuf inbuf_i (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .enq        (enq[lane]),
      .din        (lane_din[lane]),
      .full       (full[lane]),
      .leaf_full  (f_full[leaf]),
      .leaf_enq   (f_enq[leaf]),
      .leaf_din   (f_din[leaf]),
      .round_done (round_done)
    );
  end

  // Cell k merges the FIFOs of its two children into FIFO k
  for (genvar n = 1; n <= cell_cnt; n++) begin : g_cell
    localparam node_idx_t node  = node_idx_t'(n);
    localparam node_idx_t left  = node_idx_t'(2 * n);
    localparam node_idx_t right = node_idx_t'(2 * n + 1);

    merge_cell cell_i (
      .a_rdy    (~f_emp[left]),
      .b_rdy    (~f_emp[right]),
      .a_rec    (f_dot[left]),
      .b_rec    (f_dot[right]),
      .a_deq    (f_deq[left]),
      .b_deq    (f_deq[right]),
      .out_full (f_full[node]),
      .out_enq  (f_enq[node]),
      .out_rec  (f_din[node])
    );
  end

endmodule

// ==== verif/tb_merge_sort_tree.sv ====
`include "sort_defs.svh"

module tb_merge_sort_tree
  import sort_rec_pkg::*, merge_tree_pkg::*;
();

  localparam int clk_period     = 10;
  localparam int rounds         = 20;
  localparam int max_run        = 12;
  localparam int empty_round    = 7;
  localparam int timeout_cycles = rounds * `SORT_WAY * (max_run + 1) * 20;

  logic                      CLK;
  logic                      rst_n;
  sort_rec_t [`SORT_WAY-1:0] lane_din;
  logic      [`SORT_WAY-1:0] enq;
  logic      [`SORT_WAY-1:0] full;
  logic                      deq;
  sort_rec_t                 dot;
  logic                      emp;

  // Records still to be pushed per lane, all rounds back to back
  sort_rec_t lane_q [`SORT_WAY][$];
  // Expected output stream, sorted keys of each round followed by a terminator
  sort_rec_t exp_q [$];
  sort_key_t round_keys [$];

  logic [`SORT_WAY-1:0] sent_term;
  int                   rounds_done;
  int                   stall_left;
  int                   burst_left;
  sort_key_t            prev_key;

  merge_sort_tree merge_sort_tree_i (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .lane_din (lane_din),
    .enq      (enq),
    .full     (full),
    .deq      (deq),
    .dot      (dot),
    .emp      (emp)
  );

  initial begin
    CLK = 1'b0;
    forever #(clk_period / 2) CLK = ~CLK;
  end

  task automatic stop_on_failure(input string why);
    $display("Test failed");
    $fatal(1, "%s", why);
  endtask

  initial begin
    #(clk_period * (timeout_cycles + 10));
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    stop_on_failure("watchdog timeout");
  end

  // Keeps the round's keys in ascending order as they are generated
  task automatic add_model_key(input sort_key_t key);
    int pos;
    pos = 0;
    while (pos < round_keys.size() && round_keys[pos] <= key) begin
      pos++;
    end
    round_keys.insert(pos, key);
  endtask

  task automatic build_rounds();
    sort_rec_t rec;
    sort_key_t key;
    int        len;
    lane_idx_t li;
    for (int r = 0; r < rounds; r++) begin
      round_keys.delete();
      for (int l = 0; l < `SORT_WAY; l++) begin
        li  = lane_idx_t'(l);
        len = (r == empty_round) ? 0 : int'($urandom % (max_run + 1));
        // Small steps from a small start so lanes share many keys
        key = sort_key_t'($urandom % 4);
        for (int i = 0; i < len; i++) begin
          rec.key  = key;
          rec.last = 1'b0;
          lane_q[li].push_back(rec);
          add_model_key(key);
          key = key + sort_key_t'($urandom % 3);
        end
        // The terminator key is noise the tree has to ignore
        rec.key  = sort_key_t'($urandom);
        rec.last = 1'b1;
        lane_q[li].push_back(rec);
      end
      foreach (round_keys[i]) begin
        rec.key  = round_keys[i];
        rec.last = 1'b0;
        exp_q.push_back(rec);
      end
      rec.key  = '0;
      rec.last = 1'b1;
      exp_q.push_back(rec);
    end
  endtask

  // A lane whose terminator went in stays blocked until the round leaves
  task automatic check_locks();
    lane_idx_t li;
    for (int l = 0; l < `SORT_WAY; l++) begin
      li = lane_idx_t'(l);
      if (sent_term[li]) begin
        assert (full[li]) else begin
          $display("FAIL %0t: lane %0d open before round %0d left the output",
                   $time, l, rounds_done);
          stop_on_failure("lane lock released early");
        end
      end
    end
  endtask

  task automatic drive_lanes();
    lane_idx_t li;
    sort_rec_t junk;
    for (int l = 0; l < `SORT_WAY; l++) begin
      li        = lane_idx_t'(l);
      junk.key  = sort_key_t'($urandom);
      junk.last = 1'($urandom % 2);
      if (lane_q[li].size() > 0 && !full[li] && ($urandom % 10) < 7) begin
        enq[li]      = 1'b1;
        lane_din[li] = lane_q[li].pop_front();
        if (lane_din[li].last) begin
          sent_term[li] = 1'b1;
        end
      end else begin
        enq[li]      = 1'b0;
        lane_din[li] = junk;
      end
    end
  endtask

  task automatic drive_output();
    sort_rec_t exp_rec;
    logic      deq_v;
    // Occasional long stalls let the tree fill up, then a burst drains it
    if (stall_left > 0) begin
      deq_v = 1'b0;
      stall_left--;
      if (stall_left == 0) begin
        burst_left = 16;
      end
    end else if (burst_left > 0) begin
      deq_v = 1'b1;
      burst_left--;
    end else if (($urandom % 100) < 2) begin
      deq_v      = 1'b0;
      stall_left = 20 + int'($urandom % 60);
    end else begin
      deq_v = (($urandom % 10) < 6);
    end
    deq = deq_v;

    if (deq_v && !emp) begin
      exp_rec = exp_q.pop_front();
      if (exp_rec.last) begin
        assert (dot.last) else begin
          $display("FAIL %0t: round %0d expected its terminator, got key %0d",
                   $time, rounds_done, dot.key);
          stop_on_failure("missing terminator");
        end
        rounds_done++;
        sent_term = '0;
        prev_key  = '0;
      end else begin
        assert (!dot.last) else begin
          $display("FAIL %0t: round %0d ended early, key %0d still expected",
                   $time, rounds_done, exp_rec.key);
          stop_on_failure("early terminator");
        end
        assert (dot.key >= prev_key) else begin
          $display("FAIL %0t: key %0d follows larger key %0d", $time, dot.key, prev_key);
          stop_on_failure("output out of order");
        end
        assert (dot.key == exp_rec.key) else begin
          $display("FAIL %0t: round %0d got key %0d, expected %0d",
                   $time, rounds_done, dot.key, exp_rec.key);
          stop_on_failure("wrong output key");
        end
        prev_key = dot.key;
      end
    end
  endtask

  initial begin : main
    rst_n       = 1'b0;
    enq         = '0;
    deq         = 1'b0;
    lane_din    = '0;
    sent_term   = '0;
    rounds_done = 0;
    stall_left  = 0;
    burst_left  = 0;
    prev_key    = '0;
    void'($urandom(32'h91fe));
    build_rounds();

    repeat (3) @(posedge CLK);
    #1;
    rst_n = 1'b1;

    assert (emp && (full == '0)) else begin
      $display("FAIL %0t: after reset emp=%0b full=%b", $time, emp, full);
      stop_on_failure("bad idle state after reset");
    end

    while (rounds_done < rounds) begin
      check_locks();
      drive_lanes();
      drive_output();
      @(posedge CLK);
      #1;
    end

    // Nothing may trickle out once every round has been seen
    enq = '0;
    deq = 1'b1;
    repeat (4) begin
      @(posedge CLK);
      #1;
      assert (emp && (full == '0)) else begin
        $display("FAIL %0t: tree not idle after the last round, emp=%0b full=%b",
                 $time, emp, full);
        stop_on_failure("tree not idle at the end");
      end
    end

    $display("Test passed");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+src
src/sort_rec_pkg.sv
src/merge_tree_pkg.sv
src/two_entry_fifo.sv
src/lane_inbuf.sv
src/merge_cell.sv
src/merge_sort_tree.sv
verif/tb_merge_sort_tree.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f compile.f \
  --top-module tb_merge_sort_tree -o tb_merge_sort_tree

out=$(./obj_dir/tb_merge_sort_tree 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^Test passed$"; then
  exit 0
else
  echo "Simulation did not report a pass"
  exit 1
fi
